/* uart_rx.f */
hdl/uart_rx_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_rx.sv
hdl/uart_rx_fifo.sv
hdl/uart_rx_top.sv
tests/uart_rx_props.sv
tests/uart_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the UART receive testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f uart_rx.f --top-module uart_rx_tb -o uart_rx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/uart_rx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1

/* tests/uart_rx_tb.sv */
// Directed testbench for the UART receive path; sends serial frames and checks the FIFO head
`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb;

  localparam int DIVISOR  = 2;
  localparam int BIT_CLKS = uart_rx_pkg::OVERSAMPLE * DIVISOR;  // 32 clocks, 128 ns
  localparam int WAIT_MAX = 12 * BIT_CLKS;                      // Longer than any frame

  logic               clk_i;
  logic               rst_ni;
  uart_rx_pkg::csr_t  csr;
  logic               sin;
  logic               rx_pop;
  logic               fifo_clr;
  uart_rx_pkg::rx_d_t rx_q;
  logic               rx_empty;
  logic               overrun;
  logic               brk;

  uart_rx_pkg::rx_d_t exp_q[$];  // Expected FIFO contents, oldest first
  int                 errors = 0;

  uart_rx_top uart_rx_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .csr_i      (csr),
    .sin_i      (sin),
    .rx_pop_i   (rx_pop),
    .fifo_clr_i (fifo_clr),
    .rx_q_o     (rx_q),
    .rx_empty_o (rx_empty),
    .overrun_o  (overrun),
    .break_o    (brk)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // ------------------------------------------------------------
  // Line driver and reference model
  // ------------------------------------------------------------
  task automatic drive_line(input logic level, input int clocks);
    @(negedge clk_i);
    sin = level;
    repeat (clocks - 1) @(negedge clk_i);  // Level held for exactly this many clocks
  endtask

  task automatic send_frame(input logic [7:0] data, input int nbits, input logic pen,
                            input logic pbit, input logic stop_lvl, input int nstop);
    drive_line(1'b0, BIT_CLKS);  // Start bit
    for (int i = 0; i < nbits; i++)
      drive_line(data[i], BIT_CLKS);  // LSB first
    if (pen)
      drive_line(pbit, BIT_CLKS);
    drive_line(stop_lvl, nstop * BIT_CLKS);
    drive_line(1'b1, 1);  // Idle
  endtask

  function automatic uart_rx_pkg::rx_d_t model_char(input logic [7:0] data, input int nbits,
      input logic pen, input logic eps, input logic stick, input logic pbit,
      input logic stop_lvl);
    uart_rx_pkg::rx_d_t c;
    logic               ones;
    c.d  = data & (8'hFF >> (8 - nbits));
    ones = ^c.d ^ pbit;  // Odd count of ones over data and parity bit
    if (!pen)       c.pe = 1'b0;
    else if (stick) c.pe = (pbit != !eps);  // Stick bit must be the inverse of eps
    else            c.pe = eps ? ones : !ones;
    c.fe = !stop_lvl;
    c.bi = 1'b0;
    return c;
  endfunction

  task automatic set_cfg(input int nbits, input logic pen, input logic eps, input logic stick);
    @(negedge clk_i);
    csr.lcr.wls          = uart_rx_pkg::wls_t'(2'(nbits - 5));
    csr.lcr.stb          = 1'b0;
    csr.lcr.pen          = pen;
    csr.lcr.eps          = eps;
    csr.lcr.stick_parity = stick;
    csr.divisor          = 16'(DIVISOR);
  endtask

  task automatic send_char(input logic [7:0] data, input int nbits, input logic pbit,
                           input logic stop_lvl);
    exp_q.push_back(model_char(data, nbits, csr.lcr.pen, csr.lcr.eps,
                               csr.lcr.stick_parity, pbit, stop_lvl));
    send_frame(data, nbits, csr.lcr.pen, pbit, stop_lvl, 1);
  endtask

  // ------------------------------------------------------------
  // FIFO side
  // ------------------------------------------------------------
  task automatic wait_nonempty(output logic ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_i);
    while (rx_empty && n < WAIT_MAX)
    begin
      @(negedge clk_i);
      n++;
    end
    if (rx_empty)
    begin
      $display("Timed out at %0t waiting for a character in the receive FIFO", $time);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic drain_check();
    uart_rx_pkg::rx_d_t want;
    logic               ok;
    while (exp_q.size() > 0)
    begin
      want = exp_q.pop_front();
      wait_nonempty(ok);
      if (!ok)
      begin
        exp_q.delete();  // Rest would time out too
        return;
      end
      if (rx_q !== want)
      begin
        $display("Fail at %0t: got d=%h pe=%b fe=%b bi=%b, expected d=%h pe=%b fe=%b bi=%b",
                 $time, rx_q.d, rx_q.pe, rx_q.fe, rx_q.bi, want.d, want.pe, want.fe, want.bi);
        errors++;
      end
      rx_pop = 1'b1;  // Still on the falling edge
      @(negedge clk_i);
      rx_pop = 1'b0;
    end
  endtask

  task automatic clear_fifo();
    @(negedge clk_i);
    fifo_clr = 1'b1;
    @(negedge clk_i);
    fifo_clr = 1'b0;
  endtask

  // Nothing may arrive for the given number of clocks
  task automatic expect_quiet(input int clocks);
    int n;
    n = 0;
    while (rx_empty && n < clocks)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!rx_empty)
    begin
      $display("Fail at %0t: unexpected character d=%h in the receive FIFO", $time, rx_q.d);
      errors++;
      clear_fifo();
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_8n1();
    set_cfg(8, 1'b0, 1'b0, 1'b0);
    repeat (5)
    begin
      repeat (4) send_char(8'($urandom), 8, 1'b0, 1'b1);  // Four queued, read in order
      drain_check();
    end
  endtask

  task automatic test_parity();
    logic [7:0] data;
    logic       good;
    for (int nbits = 5; nbits <= 7; nbits++)
      for (int e = 1; e >= 0; e--)
      begin
        set_cfg(nbits, 1'b1, 1'(e), 1'b0);
        data = 8'($urandom);
        good = ^(data & (8'hFF >> (8 - nbits))) ^ (e == 0);  // Even or odd parity bit
        send_char(data, nbits, good, 1'b1);
        send_char(data, nbits, !good, 1'b1);
        drain_check();
      end
  endtask

  task automatic test_stick();
    for (int e = 0; e < 2; e++)
    begin
      set_cfg(8, 1'b1, 1'(e), 1'b1);
      send_char(8'($urandom), 8, 1'b0, 1'b1);
      send_char(8'($urandom), 8, 1'b1, 1'b1);
      drain_check();
    end
  endtask

  task automatic test_frame_spike();
    set_cfg(8, 1'b0, 1'b0, 1'b0);
    send_char(8'($urandom) | 8'h01, 8, 1'b0, 1'b0);  // Bit 0 high, so no break
    drain_check();
    drive_line(1'b0, 3 * DIVISOR);  // Spike of 3 baud ticks
    drive_line(1'b1, 1);
    expect_quiet(10 * BIT_CLKS);
  endtask

  task automatic test_overrun();
    logic [7:0] data;
    logic       ok;
    int         n;
    set_cfg(8, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < uart_rx_pkg::RX_FIFO_DEPTH + 1; i++)
    begin
      data = 8'($urandom);
      if (i < uart_rx_pkg::RX_FIFO_DEPTH)
        exp_q.push_back(model_char(data, 8, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
      send_frame(data, 8, 1'b0, 1'b0, 1'b1, 1);  // Last one is dropped
    end
    n = 0;
    while (!overrun && n < WAIT_MAX)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!overrun)
    begin
      $display("Fail at %0t: overrun_o low after 17 frames", $time);
      errors++;
    end
    drain_check();
    if (!overrun)
    begin
      $display("Fail at %0t: overrun_o dropped while reading the FIFO", $time);
      errors++;
    end
    send_frame(8'h5A, 8, 1'b0, 1'b0, 1'b1, 1);  // Something for the clear to drop
    wait_nonempty(ok);
    clear_fifo();
    if (!rx_empty || overrun)
    begin
      $display("Fail at %0t: after clear rx_empty=%b overrun=%b", $time, rx_empty, overrun);
      errors++;
    end
  endtask

  task automatic test_break();
    uart_rx_pkg::rx_d_t brk_char;
    int                 n;
    set_cfg(8, 1'b0, 1'b0, 1'b0);
    brk_char.d  = 8'h00;
    brk_char.pe = 1'b0;
    brk_char.fe = 1'b1;
    brk_char.bi = 1'b1;
    exp_q.push_back(brk_char);
    drive_line(1'b0, 20 * BIT_CLKS);  // Twice the 8N1 frame
    if (!brk)
    begin
      $display("Fail at %0t: break_o low after a long low line", $time);
      errors++;
    end
    drain_check();
    drive_line(1'b1, 1);
    n = 0;
    while (brk && n < WAIT_MAX)
    begin
      @(negedge clk_i);
      n++;
    end
    if (brk)
    begin
      $display("Timed out at %0t waiting for break_o to fall", $time);
      errors++;
    end
    expect_quiet(10 * BIT_CLKS);
  endtask

  initial
  begin
    void'($urandom(97));
    rst_ni      = 1'b0;
    sin         = 1'b1;
    rx_pop      = 1'b0;
    fifo_clr    = 1'b0;
    csr         = '0;
    csr.divisor = 16'(DIVISOR);
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    if (!rx_empty || overrun || brk)
    begin
      $display("Fail at %0t: outputs not in reset state", $time);
      errors++;
    end
    drive_line(1'b1, 2 * BIT_CLKS);  // Idle before the first frame

    test_8n1();
    test_parity();
    test_stick();
    test_frame_spike();
    test_overrun();
    test_break();

    $display("Run finished with %0d errors", errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/uart_rx_props.sv */
// Concurrent checks on the receiver and the receive FIFO, attached by the bind lines below
`timescale 1ns/1ps
`default_nettype none

module uart_rx_props (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire logic                   rx_side_i,  // High when bound into the receiver
  input wire logic                   push_i,
  input uart_rx_pkg::rx_state_t      state_i,
  input wire logic                   line_i,     // Synchronized serial line
  input wire logic                   break_i,
  input wire logic                   full_i,
  input wire logic                   pop_i,
  input wire logic                   clr_i,
  input wire logic                   overrun_i
);

  // ------------------------------------------------------------
  // Push strobe
  // ------------------------------------------------------------
  a_push_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |=> !push_i)
    else $error("push held high for two cycles");

  // A character only leaves the stop bit state
  a_no_idle_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_side_i && push_i) |-> $past(state_i) == uart_rx_pkg::ST_STOP)
    else $error("receiver pushed without a stop bit");

  a_overrun_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i && full_i && !pop_i && !clr_i) |=> overrun_i)
    else $error("push into a full FIFO did not set overrun");

  // Break ends as soon as the line is back high
  a_break_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_side_i && line_i) |=> !break_i)
    else $error("break still high after the line returned high");

endmodule

bind uart_rx uart_rx_props rx_props_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .rx_side_i (1'b1),
  .push_i    (push_o),
  .state_i   (state_q),
  .line_i    (line_s),
  .break_i   (break_o),
  .full_i    (1'b0),
  .pop_i     (1'b0),
  .clr_i     (1'b0),
  .overrun_i (1'b0)
);

bind uart_rx_fifo uart_rx_props fifo_props_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .rx_side_i (1'b0),
  .push_i    (push_i),
  .state_i   (uart_rx_pkg::ST_IDLE),
  .line_i    (1'b1),
  .break_i   (1'b0),
  .full_i    (full),
  .pop_i     (pop_i),
  .clr_i     (clr_i),
  .overrun_i (overrun_o)
);

`default_nettype wire

/* hdl/uart_rx_top.sv */
// UART receive path top level; baud generator, receiver and FIFO joined
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  uart_rx_pkg::csr_t      csr_i,
  input  wire logic              sin_i,
  input  wire logic              rx_pop_i,
  input  wire logic              fifo_clr_i,
  output uart_rx_pkg::rx_d_t     rx_q_o,
  output logic                   rx_empty_o,
  output logic                   overrun_o,
  output logic                   break_o
);

  logic               baudout;  // 16x bit rate strobe
  logic               rx_push;
  uart_rx_pkg::rx_d_t rx_d;     // Character from the receiver

  uart_baud_gen uart_baud_gen_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .csr_i     (csr_i),
    .baudout_o (baudout)
  );

  uart_rx uart_rx_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .baudout_i (baudout),
    .csr_i     (csr_i),
    .sin_i     (sin_i),
    .push_o    (rx_push),
    .q_o       (rx_d),
    .break_o   (break_o)
  );

  // No back-pressure, a full FIFO drops the character
  uart_rx_fifo uart_rx_fifo_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (rx_push),
    .d_i       (rx_d),
    .pop_i     (rx_pop_i),
    .clr_i     (fifo_clr_i),
    .q_o       (rx_q_o),
    .empty_o   (rx_empty_o),
    .overrun_o (overrun_o)
  );

endmodule

`default_nettype wire

/* hdl/uart_rx_fifo.sv */
// Show-ahead receive FIFO for characters and flags, with a sticky overrun flag
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              push_i,
  input  uart_rx_pkg::rx_d_t     d_i,
  input  wire logic              pop_i,
  input  wire logic              clr_i,
  output uart_rx_pkg::rx_d_t     q_o,
  output logic                   empty_o,
  output logic                   overrun_o
);

  localparam int AW = uart_rx_pkg::RX_FIFO_AW;

  uart_rx_pkg::rx_d_t mem_q [uart_rx_pkg::RX_FIFO_DEPTH];

  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;   // One extra bit to tell full from empty
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == (AW+1)'(uart_rx_pkg::RX_FIFO_DEPTH));
  assign do_pop  = pop_i & ~empty_o;            // Pop on empty is ignored
  assign do_push = push_i & (~full | do_pop);  // Room freed by a pop this cycle

  // ------------------------------------------------------------
  // Pointers, count and overrun
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_o <= 1'b0;
    end
    else if (clr_i)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_o <= 1'b0;
    end
    else
    begin
      if (do_push) wr_ptr_q <= wr_ptr_q + AW'(1);
      if (do_pop)  rd_ptr_q <= rd_ptr_q + AW'(1);

      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + (AW+1)'(1);
        2'b01:   count_q <= count_q - (AW+1)'(1);
        default: count_q <= count_q;
      endcase

      if (push_i && !do_push) overrun_o <= 1'b1;  // Character lost, sticky
    end

  // Storage
  always_ff @(posedge clk_i)
    if (do_push && !clr_i) mem_q[wr_ptr_q] <= d_i;

  assign q_o = mem_q[rd_ptr_q];  // Head shown ahead

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
// Serial receiver; oversamples the line, checks parity and stop, detects break
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              baudout_i,
  input  uart_rx_pkg::csr_t      csr_i,
  input  wire logic              sin_i,
  output logic                   push_o,
  output uart_rx_pkg::rx_d_t     q_o,
  output logic                   break_o
);

  localparam logic [3:0] TICK_MID  = 4'(uart_rx_pkg::MID_TICK);
  localparam logic [3:0] TICK_LAST = 4'(uart_rx_pkg::OVERSAMPLE - 1);

  uart_rx_pkg::rx_state_t state_q;

  logic [1:0] sync_q;       // Two-flop synchronizer, idle high
  logic       line_s;       // Synchronized line
  logic       line_tick_q;  // Line value at the previous baud tick
  logic       fall_tick;
  logic [3:0] cnt_q;        // Tick within the current bit
  logic       at_mid;
  logic       at_last;
  logic [2:0] bitcnt_q;     // Data bits left minus one
  logic [7:0] shift_q;
  logic       pe_q;
  logic       fe_q;
  logic       bi_q;
  logic       push_q;
  logic       brk_wait_q;   // Low stop bit seen, waiting for line high or break
  logic       pe_calc;
  logic [7:0] break_load;
  logic [7:0] break_cnt_q;

  // ------------------------------------------------------------
  // Line input
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      sync_q      <= 2'b11;
      line_tick_q <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[0], sin_i};
      if (baudout_i) line_tick_q <= line_s;
    end

  assign line_s    = sync_q[1];
  assign fall_tick = line_tick_q & ~line_s;  // High to low between two ticks

  assign at_mid  = (cnt_q == TICK_MID);
  assign at_last = (cnt_q == TICK_LAST);

  // Expected parity, data bits above the word length read as zero
  always_comb
    if (csr_i.lcr.stick_parity) pe_calc = line_s ^ ~csr_i.lcr.eps;  // Bit must be ~eps
    else if (csr_i.lcr.eps)     pe_calc = ^{line_s, shift_q};       // Even
    else                        pe_calc = ~^{line_s, shift_q};      // Odd

  // ------------------------------------------------------------
  // Receive FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state_q    <= uart_rx_pkg::ST_IDLE;
      cnt_q      <= '0;
      bitcnt_q   <= '0;
      pe_q       <= 1'b0;
      fe_q       <= 1'b0;
      bi_q       <= 1'b0;
      push_q     <= 1'b0;
      brk_wait_q <= 1'b0;
    end
    else
    begin
      push_q <= 1'b0;

      if (brk_wait_q)
      begin
        // Hold the character until the line recovers or a break is declared
        if (line_s || break_o)
        begin
          push_q     <= 1'b1;
          bi_q       <= break_o;
          brk_wait_q <= 1'b0;
          state_q    <= uart_rx_pkg::ST_IDLE;
        end
      end
      else if (baudout_i)
      begin
        cnt_q <= cnt_q + 4'd1;  // Wraps into tick 0 of the next bit

        case (state_q)
          uart_rx_pkg::ST_IDLE:
            if (fall_tick)
            begin
              state_q <= uart_rx_pkg::ST_START;
              cnt_q   <= 4'd1;  // Edge tick is tick 0
            end

          uart_rx_pkg::ST_START:
            if (at_mid && line_s)
              state_q <= uart_rx_pkg::ST_IDLE;  // Spike, not a start bit
            else if (at_last)
            begin
              state_q  <= uart_rx_pkg::ST_BYTE;
              bitcnt_q <= {1'b1, csr_i.lcr.wls};  // 4..7 for 5..8 bits
              pe_q     <= 1'b0;
              fe_q     <= 1'b0;
              bi_q     <= 1'b0;
            end

          uart_rx_pkg::ST_BYTE:
            if (at_last)
            begin
              if (bitcnt_q == 3'd0)
                state_q <= csr_i.lcr.pen ? uart_rx_pkg::ST_PARITY : uart_rx_pkg::ST_STOP;
              bitcnt_q <= bitcnt_q - 3'd1;
            end

          uart_rx_pkg::ST_PARITY:
            if (at_mid)       pe_q    <= pe_calc;
            else if (at_last) state_q <= uart_rx_pkg::ST_STOP;

          uart_rx_pkg::ST_STOP:
            if (at_mid)
            begin
              fe_q <= ~line_s;
              if (line_s)
              begin
                push_q  <= 1'b1;  // Normal stop, push right away
                bi_q    <= break_o;
                state_q <= uart_rx_pkg::ST_IDLE;
              end
              else
                brk_wait_q <= 1'b1;
            end

          default: state_q <= uart_rx_pkg::ST_IDLE;
        endcase
      end
    end

  // Data shift register, LSB first into the top of the word
  always_ff @(posedge clk_i)
    if (baudout_i && at_mid && state_q == uart_rx_pkg::ST_BYTE)
      case (csr_i.lcr.wls)
        uart_rx_pkg::wls_5bits: shift_q <= {3'h0, line_s, shift_q[4:1]};
        uart_rx_pkg::wls_6bits: shift_q <= {2'h0, line_s, shift_q[5:1]};
        uart_rx_pkg::wls_7bits: shift_q <= {1'h0, line_s, shift_q[6:1]};
        default:                shift_q <= {line_s, shift_q[7:1]};
      endcase

  assign push_o = push_q;
  assign q_o.d  = shift_q;
  assign q_o.pe = pe_q;
  assign q_o.fe = fe_q;
  assign q_o.bi = bi_q;

  // ------------------------------------------------------------
  // Break detection
  // ------------------------------------------------------------
  // Frame length in ticks, start + data + parity + stop
  always_comb
  begin
    break_load = 8'(uart_rx_pkg::BREAK_RESET_LOAD);
    case ({csr_i.lcr.pen, csr_i.lcr.stb, csr_i.lcr.wls})
      {2'b00, uart_rx_pkg::wls_5bits}: break_load = 8'd112;
      {2'b00, uart_rx_pkg::wls_6bits}: break_load = 8'd128;
      {2'b00, uart_rx_pkg::wls_7bits}: break_load = 8'd144;
      {2'b00, uart_rx_pkg::wls_8bits}: break_load = 8'd160;  // 8N1
      {2'b01, uart_rx_pkg::wls_5bits}: break_load = 8'd120;  // 1.5 stop bits
      {2'b01, uart_rx_pkg::wls_6bits}: break_load = 8'd144;
      {2'b01, uart_rx_pkg::wls_7bits}: break_load = 8'd160;
      {2'b01, uart_rx_pkg::wls_8bits}: break_load = 8'd176;
      {2'b10, uart_rx_pkg::wls_5bits}: break_load = 8'd128;
      {2'b10, uart_rx_pkg::wls_6bits}: break_load = 8'd144;
      {2'b10, uart_rx_pkg::wls_7bits}: break_load = 8'd160;
      {2'b10, uart_rx_pkg::wls_8bits}: break_load = 8'd176;
      {2'b11, uart_rx_pkg::wls_5bits}: break_load = 8'd136;
      {2'b11, uart_rx_pkg::wls_6bits}: break_load = 8'd160;
      {2'b11, uart_rx_pkg::wls_7bits}: break_load = 8'd176;
      {2'b11, uart_rx_pkg::wls_8bits}: break_load = 8'd192;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)                        break_cnt_q <= 8'(uart_rx_pkg::BREAK_RESET_LOAD);
    else if (line_s)                    break_cnt_q <= break_load;  // Reload while idle high
    else if (baudout_i && |break_cnt_q) break_cnt_q <= break_cnt_q - 8'd1;

  assign break_o = ~|break_cnt_q;  // Line low for a full frame

endmodule

`default_nettype wire

/* hdl/uart_baud_gen.sv */
// 16x baud strobe generator; pulses baudout_o once every divisor clocks
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  uart_rx_pkg::csr_t      csr_i,
  output logic                   baudout_o
);

  logic [15:0] cnt_q;   // Clocks left until the next strobe
  logic        expire;

  assign expire = (cnt_q <= 16'd1);  // Also true right after reset or a zero divisor

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      cnt_q     <= '0;
      baudout_o <= 1'b0;
    end
    else if (csr_i.divisor == 16'd0)
    begin
      cnt_q     <= '0;            // Divisor of zero halts the strobe
      baudout_o <= 1'b0;
    end
    else
    begin
      baudout_o <= expire;
      cnt_q     <= expire ? csr_i.divisor : cnt_q - 16'd1;  // New divisor used on reload
    end

endmodule

`default_nettype wire

/* hdl/uart_rx_pkg.sv */
// Shared types and constants for the UART receiver; referenced by scoped name
`default_nettype none

package uart_rx_pkg;

  // ------------------------------------------------------------
  // Oversampling and FIFO sizing
  // ------------------------------------------------------------
  localparam int OVERSAMPLE       = 16;   // Baud ticks per bit
  localparam int MID_TICK         = 7;    // Sample point inside a bit
  localparam int RX_FIFO_DEPTH    = 16;
  localparam int RX_FIFO_AW       = 4;    // log2 of the depth
  localparam int BREAK_RESET_LOAD = 176;  // Break counter value out of reset

  // Word length select, LCR[1:0] encoding
  typedef enum logic [1:0] {
    wls_5bits = 2'b00,
    wls_6bits = 2'b01,
    wls_7bits = 2'b10,
    wls_8bits = 2'b11
  } wls_t;

  // Line control fields used by the receive path
  typedef struct packed {
    wls_t wls;
    logic stb;           // 1 or 2 stop bits, only changes break length
    logic pen;           // Parity enable
    logic eps;           // Even parity select
    logic stick_parity;
  } lcr_t;

  typedef struct packed {
    lcr_t        lcr;
    logic [15:0] divisor;  // Divisor latch
  } csr_t;

  // One received character with its error flags
  typedef struct packed {
    logic [7:0] d;   // Right aligned, unused upper bits zero
    logic       pe;  // Parity error
    logic       fe;  // Framing error
    logic       bi;  // Break
  } rx_d_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_START, ST_BYTE, ST_PARITY, ST_STOP
  } rx_state_t;

endpackage

`default_nettype wire
